/* rs232_bridge.f */
hdl/rs232_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_regs.sv
hdl/rs232_master.sv
hdl/rs232_top.sv
tests/rs232_chk.sv
tests/rs232_tb.sv

/* Makefile */
.PHONY: run clean

obj_dir/Vrs232_tb: rs232_bridge.f $(wildcard hdl/*.sv) $(wildcard tests/*.sv)
	verilator --binary --timing --assert --top-module rs232_tb -f rs232_bridge.f

run: obj_dir/Vrs232_tb
	@out="$$(./obj_dir/Vrs232_tb)"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

/* tests/rs232_tb.sv */
`default_nettype none

module rs232_tb;

    localparam int bit_clks   = 16;
    localparam int wait_limit = 40 * bit_clks;

    logic       avm_clk;
    logic       avm_rst;
    logic       rxd;
    logic [7:0] computer_data;
    logic       ready_to_send;
    wire        txd;
    wire  [7:0] user_data;
    wire        read_finished;

    logic [7:0] got_q[$];
    int         seed;
    int         errors;
    int         mark;
    int         pass_cnt;
    int         fail_cnt;

    rs232_top #(
        .clks_per_bit (bit_clks)
    ) i_rs232_top (
        .avm_clk       (avm_clk),
        .avm_rst       (avm_rst),
        .rxd           (rxd),
        .txd           (txd),
        .user_data     (user_data),
        .read_finished (read_finished),
        .computer_data (computer_data),
        .ready_to_send (ready_to_send)
    );

    initial begin
        avm_clk = 1'b0;
        forever #5 avm_clk = ~avm_clk;
    end

    // every delivered byte, in order
    always @(negedge avm_clk) begin
        if (avm_rst === 1'b1 && read_finished === 1'b1) begin
            got_q.push_back(user_data);
        end
    end

    task automatic flag_error(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic abort_run(input string what);
        $display("%0t: %s", $time, what);
        $display("Test failed");
        $finish;
    endtask

    task automatic end_test(input string name);
        if (errors == mark) begin
            pass_cnt++;
            $display("%s: passed", name);
        end else begin
            fail_cnt++;
            $display("%s: failed", name);
        end
        mark = errors;
    endtask

    task automatic send_frame(input logic [7:0] data, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rxd = frame[i];
            repeat (bit_clks) @(negedge avm_clk);
        end
        rxd = 1'b1;
    endtask

    // samples txd in the middle of each bit
    task automatic decode_frame(output logic [7:0] data, output logic stop_bit);
        int n;
        n = 0;
        while (txd !== 1'b0 && n < wait_limit) begin
            @(negedge avm_clk);
            n++;
        end
        if (txd !== 1'b0) begin
            abort_run("no start bit ever appeared on txd");
        end else begin
            repeat (bit_clks / 2) @(negedge avm_clk);
            assert (txd == 1'b0) else flag_error("start bit on txd did not stay low");
            for (int i = 0; i < 8; i++) begin
                repeat (bit_clks) @(negedge avm_clk);
                data[i] = txd;
            end
            repeat (bit_clks) @(negedge avm_clk);
            stop_bit = txd;
        end
    endtask

    task automatic wait_delivery(output logic [7:0] data);
        int n;
        n = 0;
        while (got_q.size() == 0 && n < wait_limit) begin
            @(negedge avm_clk);
            n++;
        end
        if (got_q.size() == 0) begin
            abort_run("no read_finished pulse came for a received byte");
        end else begin
            data = got_q.pop_front();
        end
    endtask

    task automatic watch_idle(input int cycles);
        repeat (cycles) begin
            @(negedge avm_clk);
            assert (txd == 1'b1) else flag_error("txd left idle");
            assert (read_finished == 1'b0) else flag_error("unexpected read_finished");
        end
    endtask

    task automatic check_receive(input logic [7:0] sent);
        logic [7:0] got;
        send_frame(sent, 1'b1);
        wait_delivery(got);
        assert (got == sent)
            else flag_error($sformatf("user_data %02h, expected %02h", got, sent));
        repeat (2 * bit_clks) @(negedge avm_clk);
        assert (got_q.size() == 0) else flag_error("extra read_finished pulse");
    endtask

    task automatic check_reply(input logic [7:0] reply);
        logic [7:0] got;
        logic       stop_bit;
        computer_data = reply;
        ready_to_send = 1'b1;
        @(negedge avm_clk);
        ready_to_send = 1'b0;
        decode_frame(got, stop_bit);
        assert (got == reply)
            else flag_error($sformatf("txd byte %02h, expected %02h", got, reply));
        assert (stop_bit == 1'b1) else flag_error("stop bit on txd read as 0");
    endtask

    initial begin
        logic [7:0] got;
        logic [7:0] rx_b;
        logic [7:0] tx_b;
        avm_rst       = 1'b0;
        rxd           = 1'b1;
        computer_data = 8'h00;
        ready_to_send = 1'b0;
        errors        = 0;
        mark          = 0;
        pass_cnt      = 0;
        fail_cnt      = 0;
        seed          = 59409;
        repeat (2) @(negedge avm_clk);
        avm_rst = 1'b1;

        watch_idle(20 * bit_clks);
        end_test("idle after reset");

        check_receive(8'hA5);
        end_test("single byte delivery");

        check_reply(8'h3C);
        end_test("single reply frame");

        // reply held back while a second byte arrives
        check_receive(8'h5A);
        fork
            send_frame(8'hC3, 1'b1);
            watch_idle(14 * bit_clks);
        join
        assert (got_q.size() == 0) else flag_error("second byte delivered before reply");
        check_reply(8'h81);
        wait_delivery(got);
        assert (got == 8'hC3)
            else flag_error($sformatf("user_data %02h, expected c3", got));
        check_reply(8'h7E);
        end_test("held reply and queued byte");

        send_frame(8'h66, 1'b0);
        watch_idle(4 * bit_clks);
        check_receive(8'h99);
        check_reply(8'h18);
        end_test("bad stop bit dropped");

        for (int r = 0; r < 8; r++) begin
            rx_b = 8'($random(seed));
            tx_b = 8'($random(seed));
            check_receive(rx_b);
            check_reply(tx_b);
        end
        end_test("random rounds");

        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && i_rs232_top.i_rs232_master.i_rs232_chk.error_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/rs232_chk.sv */
`default_nettype none

module rs232_chk
    import rs232_pkg::*;
(
    input wire                  avm_clk,
    input wire                  avm_rst,
    input wire [avm_addr_w-1:0] avm_address,
    input wire                  avm_read,
    input wire                  avm_write,
    input wire                  avm_waitrequest,
    input wire                  read_finished
);

    // read by the testbench at the end of the run
    int error_cnt = 0;

    a_single_pulse: assert property (@(posedge avm_clk) disable iff (!avm_rst)
        read_finished |=> !read_finished)
        else begin
            $error("read_finished stayed high for two cycles");
            error_cnt++;
        end

    a_one_strobe: assert property (@(posedge avm_clk) disable iff (!avm_rst)
        !(avm_read && avm_write))
        else begin
            $error("avm_read and avm_write high together");
            error_cnt++;
        end

    // a stalled access keeps its command
    a_hold_on_wait: assert property (@(posedge avm_clk) disable iff (!avm_rst)
        avm_waitrequest |=> $stable(avm_address) && $stable(avm_read) && $stable(avm_write))
        else begin
            $error("bus command changed while waitrequest was high");
            error_cnt++;
        end

    // low after reset until a read of the rx register completes
    a_finish_after_read: assert property (@(posedge avm_clk) disable iff (!avm_rst)
        read_finished |-> $past(avm_read && !avm_waitrequest && avm_address == rx_addr))
        else begin
            $error("read_finished high without a completed rx data read");
            error_cnt++;
        end

endmodule

bind rs232_master rs232_chk i_rs232_chk (
    .avm_clk         (avm_clk),
    .avm_rst         (avm_rst),
    .avm_address     (avm_address),
    .avm_read        (avm_read),
    .avm_write       (avm_write),
    .avm_waitrequest (avm_waitrequest),
    .read_finished   (read_finished)
);

`default_nettype wire

/* hdl/rs232_top.sv */
`default_nettype none

module rs232_top
    import rs232_pkg::*;
#(
    parameter int clks_per_bit = 16
) (
    input  wire        avm_clk,
    input  wire        avm_rst,
    input  wire        rxd,
    output logic       txd,
    output logic [7:0] user_data,
    output logic       read_finished,
    input  wire  [7:0] computer_data,
    input  wire        ready_to_send
);

    logic [avm_addr_w-1:0] avm_address;
    logic                  avm_read;
    logic                  avm_write;
    logic [avm_data_w-1:0] avm_writedata;
    logic [avm_data_w-1:0] avm_readdata;
    logic                  avm_waitrequest;
    logic                  tx_start;
    logic [7:0]            tx_data;
    logic                  tx_busy;
    logic                  rx_valid;
    logic [7:0]            rx_data;

    rs232_master i_rs232_master (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_readdata    (avm_readdata),
        .avm_waitrequest (avm_waitrequest),
        .user_data       (user_data),
        .read_finished   (read_finished),
        .computer_data   (computer_data),
        .ready_to_send   (ready_to_send)
    );

    uart_regs i_uart_regs (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_write       (avm_write),
        .avm_writedata   (avm_writedata),
        .avm_readdata    (avm_readdata),
        .avm_waitrequest (avm_waitrequest),
        .tx_start        (tx_start),
        .tx_data         (tx_data),
        .tx_busy         (tx_busy),
        .rx_valid        (rx_valid),
        .rx_data         (rx_data)
    );

    uart_tx #(
        .clks_per_bit (clks_per_bit)
    ) i_uart_tx (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy),
        .txd      (txd)
    );

    uart_rx #(
        .clks_per_bit (clks_per_bit)
    ) i_uart_rx (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .rxd      (rxd),
        .rx_valid (rx_valid),
        .rx_data  (rx_data)
    );

endmodule

`default_nettype wire

/* hdl/rs232_master.sv */
`default_nettype none

module rs232_master
    import rs232_pkg::*;
(
    input  wire                   avm_clk,
    input  wire                   avm_rst,
    output logic [avm_addr_w-1:0] avm_address,
    output logic                  avm_read,
    output logic                  avm_write,
    output logic [avm_data_w-1:0] avm_writedata,
    input  wire  [avm_data_w-1:0] avm_readdata,
    input  wire                   avm_waitrequest,
    output logic [7:0]            user_data,
    output logic                  read_finished,
    input  wire  [7:0]            computer_data,
    input  wire                   ready_to_send
);

    master_state_t         state_r, state_w;
    logic [avm_addr_w-1:0] address_r, address_w;
    logic                  read_r, read_w;
    logic                  write_r, write_w;
    logic                  finished_r, finished_w;
    logic [7:0]            reply_r;
    logic                  rd_done;
    logic                  wr_done;

    assign avm_address   = address_r;
    assign avm_read      = read_r;
    assign avm_write     = write_r;
    assign avm_writedata = {{(avm_data_w - 8){1'b0}}, reply_r};
    assign read_finished = finished_r;

    // access completes once waitrequest drops
    assign rd_done = read_r && !avm_waitrequest;
    assign wr_done = write_r && !avm_waitrequest;

    always_comb begin
        state_w    = state_r;
        address_w  = address_r;
        read_w     = read_r;
        write_w    = write_r;
        finished_w = 1'b0;
        case (state_r)
            st_poll_rx: begin
                // keep polling until a byte is waiting
                if (rd_done && avm_readdata[rx_ok_bit]) begin
                    state_w   = st_read_rx;
                    address_w = rx_addr;
                end
            end
            st_read_rx: begin
                if (rd_done) begin
                    state_w    = st_wait_user;
                    read_w     = 1'b0;
                    finished_w = 1'b1;
                end
            end
            st_wait_user: begin
                if (ready_to_send) begin
                    state_w   = st_poll_tx;
                    address_w = status_addr;
                    read_w    = 1'b1;
                end
            end
            st_poll_tx: begin
                if (rd_done && avm_readdata[tx_ok_bit]) begin
                    state_w   = st_write_tx;
                    address_w = tx_addr;
                    read_w    = 1'b0;
                    write_w   = 1'b1;
                end
            end
            st_write_tx: begin
                if (wr_done) begin
                    state_w   = st_poll_rx;
                    address_w = status_addr;
                    read_w    = 1'b1;
                    write_w   = 1'b0;
                end
            end
            default: begin
                state_w   = st_poll_rx;
                address_w = status_addr;
                read_w    = 1'b1;
                write_w   = 1'b0;
            end
        endcase
    end

    always_ff @(posedge avm_clk or negedge avm_rst) begin
        if (!avm_rst) begin
            state_r    <= st_poll_rx;
            address_r  <= status_addr;
            read_r     <= 1'b1;
            write_r    <= 1'b0;
            finished_r <= 1'b0;
        end else begin
            state_r    <= state_w;
            address_r  <= address_w;
            read_r     <= read_w;
            write_r    <= write_w;
            finished_r <= finished_w;
        end
    end

    // received byte stays visible until the next rx read
    always_ff @(posedge avm_clk) begin
        if (state_r == st_read_rx && rd_done) begin
            user_data <= avm_readdata[7:0];
        end
        if (state_r == st_wait_user && ready_to_send) begin
            reply_r <= computer_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/uart_regs.sv */
`default_nettype none

module uart_regs
    import rs232_pkg::*;
(
    input  wire                   avm_clk,
    input  wire                   avm_rst,
    input  wire  [avm_addr_w-1:0] avm_address,
    input  wire                   avm_read,
    input  wire                   avm_write,
    input  wire  [avm_data_w-1:0] avm_writedata,
    output logic [avm_data_w-1:0] avm_readdata,
    output logic                  avm_waitrequest,
    output logic                  tx_start,
    output logic [7:0]            tx_data,
    input  wire                   tx_busy,
    input  wire                   rx_valid,
    input  wire  [7:0]            rx_data
);

    logic                  rd_armed;
    logic                  rd_done;
    logic                  tx_sel;
    logic                  rx_sel;
    logic                  rx_ok;
    logic                  tx_ok;
    logic                  tx_pending;
    logic [7:0]            rx_byte;
    logic [avm_data_w-1:0] status_word;

    // first cycle of every read waits while readdata is registered
    assign avm_waitrequest = avm_read && !rd_armed;
    assign rd_done         = avm_read && rd_armed;

    assign tx_sel = avm_write && (avm_address == tx_addr);
    assign rx_sel = rd_done && (avm_address == rx_addr);

    // busy covers the frame, pending covers the gap before it starts
    assign tx_ok = !tx_pending && !tx_busy;

    always_comb begin
        status_word            = '0;
        status_word[rx_ok_bit] = rx_ok;
        status_word[tx_ok_bit] = tx_ok;
    end

    always_ff @(posedge avm_clk or negedge avm_rst) begin
        if (!avm_rst) begin
            rd_armed   <= 1'b0;
            rx_ok      <= 1'b0;
            tx_pending <= 1'b0;
            tx_start   <= 1'b0;
        end else begin
            rd_armed <= avm_read && !rd_armed;
            tx_start <= tx_sel;
            if (tx_sel) begin
                tx_pending <= 1'b1;
            end else if (tx_busy) begin
                tx_pending <= 1'b0;
            end
            // a fresh byte wins over the read that clears the flag
            if (rx_valid) begin
                rx_ok <= 1'b1;
            end else if (rx_sel) begin
                rx_ok <= 1'b0;
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (rx_valid) begin
            rx_byte <= rx_data;
        end
        if (tx_sel) begin
            tx_data <= avm_writedata[7:0];
        end
        if (avm_waitrequest) begin
            case (avm_address)
                rx_addr:     avm_readdata <= {{(avm_data_w - 8){1'b0}}, rx_byte};
                status_addr: avm_readdata <= status_word;
                default:     avm_readdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/uart_rx.sv */
`default_nettype none

module uart_rx
    import rs232_pkg::*;
#(
    parameter int clks_per_bit = 16
) (
    input  wire        avm_clk,
    input  wire        avm_rst,
    input  wire        rxd,
    output logic       rx_valid,
    output logic [7:0] rx_data
);

    localparam int cnt_w = $clog2(clks_per_bit);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clks_per_bit - 1);
    localparam logic [cnt_w-1:0] cnt_half = cnt_w'(clks_per_bit / 2 - 1);

    line_state_t      state;
    logic [cnt_w-1:0] cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shreg;
    logic             rxd_meta;
    logic             rxd_sync;
    logic             stop_err;
    logic             bit_end;

    assign bit_end = (cnt == cnt_last);
    assign rx_data = shreg;

    always_ff @(posedge avm_clk or negedge avm_rst) begin
        if (!avm_rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            state    <= ln_idle;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
            stop_err <= 1'b0;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rx_valid <= 1'b0;
            cnt      <= bit_end ? '0 : cnt + 1'b1;
            case (state)
                ln_idle: begin
                    cnt <= '0;
                    if (!rxd_sync) begin
                        state <= ln_start;
                    end
                end
                ln_start: begin
                    // glitch check halfway into the start bit
                    if (cnt == cnt_half) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rxd_sync ? ln_idle : ln_data;
                    end
                end
                ln_data: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= ln_stop;
                        end
                    end
                end
                default: begin
                    if (stop_err) begin
                        // bad frame, wait for the line to go idle
                        cnt <= cnt;
                        if (rxd_sync) begin
                            state    <= ln_idle;
                            stop_err <= 1'b0;
                        end
                    end else if (bit_end) begin
                        if (rxd_sync) begin
                            rx_valid <= 1'b1;
                            state    <= ln_idle;
                        end else begin
                            stop_err <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // mid-bit samples, lsb arrives first
    always_ff @(posedge avm_clk) begin
        if (state == ln_data && bit_end) begin
            shreg <= {rxd_sync, shreg[7:1]};
        end
    end

endmodule

`default_nettype wire

/* hdl/uart_tx.sv */
`default_nettype none

module uart_tx
    import rs232_pkg::*;
#(
    parameter int clks_per_bit = 16
) (
    input  wire        avm_clk,
    input  wire        avm_rst,
    input  wire        tx_start,
    input  wire  [7:0] tx_data,
    output logic       tx_busy,
    output logic       txd
);

    localparam int cnt_w = $clog2(clks_per_bit);
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(clks_per_bit - 1);

    line_state_t      state;
    logic [cnt_w-1:0] cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shreg;
    logic             bit_end;

    assign bit_end = (cnt == cnt_last);

    always_ff @(posedge avm_clk or negedge avm_rst) begin
        if (!avm_rst) begin
            state   <= ln_idle;
            cnt     <= '0;
            bit_idx <= '0;
            tx_busy <= 1'b0;
            txd     <= 1'b1;
        end else begin
            cnt <= bit_end ? '0 : cnt + 1'b1;
            case (state)
                ln_idle: begin
                    cnt <= '0;
                    if (tx_start) begin
                        state   <= ln_start;
                        tx_busy <= 1'b1;
                        txd     <= 1'b0;
                    end
                end
                ln_start: begin
                    if (bit_end) begin
                        state   <= ln_data;
                        bit_idx <= '0;
                        txd     <= shreg[0];
                    end
                end
                ln_data: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= ln_stop;
                            txd   <= 1'b1;
                        end else begin
                            txd <= shreg[0];
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state   <= ln_idle;
                        tx_busy <= 1'b0;
                    end
                end
            endcase
        end
    end

    // lsb leaves first
    always_ff @(posedge avm_clk) begin
        if (state == ln_idle && tx_start) begin
            shreg <= tx_data;
        end else if (bit_end && (state == ln_start || state == ln_data)) begin
            shreg <= shreg >> 1;
        end
    end

endmodule

`default_nettype wire

/* hdl/rs232_pkg.sv */
`default_nettype none

package rs232_pkg;

    // avalon bus widths
    parameter int avm_addr_w = 5;
    parameter int avm_data_w = 32;

    // register byte offsets
    parameter logic [avm_addr_w-1:0] rx_addr     = 5'd0;
    parameter logic [avm_addr_w-1:0] tx_addr     = 5'd4;
    parameter logic [avm_addr_w-1:0] status_addr = 5'd8;

    // status register flags
    parameter int tx_ok_bit = 6;
    parameter int rx_ok_bit = 7;

    typedef enum logic [2:0] {
        st_poll_rx,
        st_read_rx,
        st_wait_user,
        st_poll_tx,
        st_write_tx
    } master_state_t;

    // shared by serializer and deserializer
    typedef enum logic [1:0] {
        ln_idle,
        ln_start,
        ln_data,
        ln_stop
    } line_state_t;

endpackage

`default_nettype wire
